//--- design/fb_pkg.sv
// framebuffer demo package
// screen and framebuffer sizes, palette, shared structs and draw states

package fb_pkg;

    // display timing, 16x12 active area
    localparam int h_active = 16;
    localparam int h_fp     = 2;   // front porch
    localparam int h_sync   = 3;
    localparam int h_bp     = 3;   // back porch
    localparam int h_total  = h_active + h_fp + h_sync + h_bp;  // 24
    localparam int hs_start = h_active + h_fp;
    localparam int hs_end   = hs_start + h_sync;

    localparam int v_active = 12;
    localparam int v_fp     = 1;
    localparam int v_sync   = 2;
    localparam int v_bp     = 1;
    localparam int v_total  = v_active + v_fp + v_sync + v_bp;  // 16
    localparam int vs_start = v_active + v_fp;
    localparam int vs_end   = vs_start + v_sync;

    // framebuffer, one colour index per pixel
    localparam int fb_w      = 16;
    localparam int fb_h      = 12;
    localparam int fb_pixels = fb_w * fb_h;        // 192
    localparam int fb_addrw  = $clog2(fb_pixels);  // 8
    localparam int cidxw     = 4;
    localparam int chanw     = 4;
    localparam int colrw     = 3 * chanw;
    localparam int cordw     = 5;                  // unsigned screen coords

    // square and pipeline
    localparam int sq_size    = 4;
    localparam int sq_y       = 4;
    localparam int sq_span    = fb_w - sq_size + 1;  // 13 x positions
    localparam int sq_colours = 15;                  // indices 1..15
    localparam int cnt_wrap   = sq_span * sq_colours;
    localparam int lat_addr   = 2;  // draw coords to write address
    localparam int lat_pix    = 3;  // timing position to rgb out

    // fixed palette, entry 0 black
    localparam logic [colrw-1:0] palette [16] = '{
        12'h000, 12'hf00, 12'h0f0, 12'h00f,
        12'hff0, 12'h0ff, 12'hf0f, 12'hfff,
        12'h800, 12'h080, 12'h008, 12'h880,
        12'h088, 12'h808, 12'h888, 12'hf80
    };

    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
    } sync_t;

    typedef struct packed {
        logic [chanw-1:0] r;
        logic [chanw-1:0] g;
        logic [chanw-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic                we;
        logic [fb_addrw-1:0] addr;
        logic [cidxw-1:0]    cidx;
    } fb_wr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_swap,
        st_clear,
        st_draw,
        st_done
    } draw_state_e;

endpackage

//--- design/bram_sdp.sv
// simple dual-port block RAM
// one write port, one registered read port, contents start at zero

`timescale 1ns/1ps

module bram_sdp #(
    parameter int width = 4,
    parameter int depth = 192
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr_write,
    input  logic [$clog2(depth)-1:0] addr_read,
    input  logic [width-1:0]         data_in,
    output logic [width-1:0]         data_out
);

    logic [width-1:0] mem [depth];

    // power-up contents, blank screen
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
        data_out <= mem[addr_read];  // one cycle read latency
    end

endmodule

//--- design/display_timing.sv
// display timing for the 16x12 screen
// pixel and line counters, positive syncs, data enable, frame pulse

`timescale 1ns/1ps

module display_timing (
    input  logic                       clk_sys,
    input  logic                       rst_sys,
    output logic [fb_pkg::cordw-1:0]   sx,
    output logic [fb_pkg::cordw-1:0]   sy,
    output fb_pkg::sync_t              sync,
    output logic                       frame
);

    logic [fb_pkg::cordw-1:0] sx_n;  // next position
    logic [fb_pkg::cordw-1:0] sy_n;

    always_comb begin
        if (sx == fb_pkg::cordw'(fb_pkg::h_total - 1)) begin
            sx_n = '0;
            if (sy == fb_pkg::cordw'(fb_pkg::v_total - 1)) begin
                sy_n = '0;
            end else begin
                sy_n = sy + 1'b1;
            end
        end else begin
            sx_n = sx + 1'b1;
            sy_n = sy;
        end
    end

    // flags decoded from the next position so they line up with sx/sy
    always_ff @(posedge clk_sys) begin
        sx          <= sx_n;
        sy          <= sy_n;
        sync.de     <= (sx_n < fb_pkg::h_active) && (sy_n < fb_pkg::v_active);
        sync.hsync  <= (sx_n >= fb_pkg::hs_start) && (sx_n < fb_pkg::hs_end);
        sync.vsync  <= (sy_n >= fb_pkg::vs_start) && (sy_n < fb_pkg::vs_end);
        frame       <= (sx_n == '0) && (sy_n == fb_pkg::cordw'(fb_pkg::v_active));
        if (rst_sys) begin
            sx          <= '0;
            sy          <= '0;
            sync.de     <= 1'b1;  // (0,0) is an active pixel
            sync.hsync  <= 1'b0;
            sync.vsync  <= 1'b0;
            frame       <= 1'b0;
        end
    end

    // horizontal counter wraps before h_total
    a_sx_range: assert property (@(posedge clk_sys) disable iff (rst_sys)
        sx < fb_pkg::h_total)
    else $error("sx out of range: %0d", sx);

endmodule

//--- design/draw_ctrl.sv
// draw controller
// per frame: swap banks, clear back bank, render a moving 4x4 square

`timescale 1ns/1ps

module draw_ctrl (
    input  logic           clk_sys,
    input  logic           rst_sys,
    input  logic           frame,
    output fb_pkg::fb_wr_t fb_wr,
    output logic           swap
);

    fb_pkg::draw_state_e state;

    logic [fb_pkg::fb_addrw-1:0]          clr_addr;   // linear clear address
    logic [$clog2(fb_pkg::cnt_wrap)-1:0]  frame_cnt;  // draws so far, wrapped
    logic [fb_pkg::cordw-1:0]             sq_x0;      // left edge this draw
    logic [fb_pkg::cidxw-1:0]             sq_cidx;    // colour this draw

    // renderer handshake
    logic start;
    logic done;
    logic drawing;
    logic [fb_pkg::cordw-1:0] drx;  // draw coords
    logic [fb_pkg::cordw-1:0] dry;

    // address pipeline
    logic [fb_pkg::cordw-1:0]    ax_p1;
    logic [fb_pkg::fb_addrw-1:0] ay_p1;     // row base, y * fb_w
    logic [fb_pkg::fb_addrw-1:0] addr_rnd;
    logic [fb_pkg::lat_addr-1:0] we_sr;     // drawing delayed to match addr

    assign swap = (state == fb_pkg::st_swap);  // single cycle, idle -> swap

    // draw k goes to the back bank and becomes front at the next swap
    always_ff @(posedge clk_sys) begin
        start <= 1'b0;
        case (state)
            fb_pkg::st_idle: begin
                if (frame) state <= fb_pkg::st_swap;
            end
            fb_pkg::st_swap: begin
                state    <= fb_pkg::st_clear;
                clr_addr <= '0;
            end
            fb_pkg::st_clear: begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == fb_pkg::fb_addrw'(fb_pkg::fb_pixels - 1)) begin
                    state   <= fb_pkg::st_draw;
                    start   <= 1'b1;
                    // latch square position and colour for this draw
                    sq_x0   <= fb_pkg::cordw'(frame_cnt % fb_pkg::sq_span);
                    sq_cidx <= fb_pkg::cidxw'(1 + frame_cnt % fb_pkg::sq_colours);
                    if (frame_cnt == ($bits(frame_cnt))'(fb_pkg::cnt_wrap - 1)) begin
                        frame_cnt <= '0;
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                    end
                end
            end
            fb_pkg::st_draw: begin
                if (done) state <= fb_pkg::st_done;
            end
            fb_pkg::st_done: state <= fb_pkg::st_idle;
            default: state <= fb_pkg::st_idle;
        endcase
        if (rst_sys) begin
            state     <= fb_pkg::st_idle;
            start     <= 1'b0;
            frame_cnt <= '0;
        end
    end

    // square renderer, one pixel per cycle, row by row
    always_ff @(posedge clk_sys) begin
        done <= 1'b0;
        if (start) begin
            drawing <= 1'b1;
            drx     <= sq_x0;
            dry     <= fb_pkg::cordw'(fb_pkg::sq_y);
        end else if (drawing) begin
            if (drx == sq_x0 + fb_pkg::cordw'(fb_pkg::sq_size - 1)) begin
                drx <= sq_x0;  // next row
                if (dry == fb_pkg::cordw'(fb_pkg::sq_y + fb_pkg::sq_size - 1)) begin
                    drawing <= 1'b0;
                    done    <= 1'b1;  // last pixel issued
                end else begin
                    dry <= dry + 1'b1;
                end
            end else begin
                drx <= drx + 1'b1;
            end
        end
        if (rst_sys) begin
            drawing <= 1'b0;
            done    <= 1'b0;
        end
    end

    // addr = y * fb_w + x over two stages
    always_ff @(posedge clk_sys) begin
        ax_p1    <= drx;
        ay_p1    <= fb_pkg::fb_addrw'(dry * fb_pkg::fb_w);
        addr_rnd <= ay_p1 + fb_pkg::fb_addrw'(ax_p1);
    end

    always_ff @(posedge clk_sys) begin
        we_sr <= {drawing, we_sr[fb_pkg::lat_addr-1:1]};
        if (rst_sys) we_sr <= '0;
    end

    // clear and render share the write port
    always_ff @(posedge clk_sys) begin
        fb_wr.we   <= (state == fb_pkg::st_clear) || we_sr[0];
        fb_wr.addr <= (state == fb_pkg::st_clear) ? clr_addr : addr_rnd;
        fb_wr.cidx <= (state == fb_pkg::st_clear) ? '0 : sq_cidx;  // clear to black
        if (rst_sys) fb_wr.we <= 1'b0;
    end

    // whole draw sequence fits between frame pulses
    a_frame_in_idle: assert property (@(posedge clk_sys) disable iff (rst_sys)
        frame |-> state == fb_pkg::st_idle)
    else $error("frame pulse while drawing, state %s", state.name());

    a_wr_addr: assert property (@(posedge clk_sys) disable iff (rst_sys)
        fb_wr.we |-> fb_wr.addr < fb_pkg::fb_pixels)
    else $error("write address out of range: %0d", fb_wr.addr);

endmodule

//--- design/fb_double.sv
// double framebuffer
// draw side writes the back bank, display side reads the front bank

`timescale 1ns/1ps

module fb_double (
    input  logic                       clk_sys,
    input  logic                       rst_sys,
    input  fb_pkg::fb_wr_t             fb_wr,
    input  logic                       swap,
    input  logic [fb_pkg::cordw-1:0]   sx,
    input  logic [fb_pkg::cordw-1:0]   sy,
    input  logic                       de,
    output logic [fb_pkg::cidxw-1:0]   cidx_rd
);

    logic                        front;    // bank shown on screen
    logic [1:0]                  we_bank;
    logic [fb_pkg::fb_addrw-1:0] addr_rd;
    logic [fb_pkg::cidxw-1:0]    rd_0;
    logic [fb_pkg::cidxw-1:0]    rd_1;

    always_ff @(posedge clk_sys) begin
        if (swap) front <= ~front;
        if (rst_sys) front <= 1'b0;
    end

    // writes only ever reach the back bank
    assign we_bank[0] = fb_wr.we && front;
    assign we_bank[1] = fb_wr.we && !front;

    // linear read address, parked at 0 in blanking
    assign addr_rd = de ? fb_pkg::fb_addrw'(sy * fb_pkg::fb_w + sx) : '0;

    bram_sdp #(
        .width (fb_pkg::cidxw),
        .depth (fb_pkg::fb_pixels)
    ) bram_0_inst (
        .clk_sys    (clk_sys),
        .we         (we_bank[0]),
        .addr_write (fb_wr.addr),
        .addr_read  (addr_rd),
        .data_in    (fb_wr.cidx),
        .data_out   (rd_0)
    );

    bram_sdp #(
        .width (fb_pkg::cidxw),
        .depth (fb_pkg::fb_pixels)
    ) bram_1_inst (
        .clk_sys    (clk_sys),
        .we         (we_bank[1]),
        .addr_write (fb_wr.addr),
        .addr_read  (addr_rd),
        .data_in    (fb_wr.cidx),
        .data_out   (rd_1)
    );

    // second cycle of read latency
    always_ff @(posedge clk_sys) begin
        cidx_rd <= front ? rd_1 : rd_0;
    end

    // a write on the flip edge would land in the new front bank
    a_no_wr_on_swap: assert property (@(posedge clk_sys) disable iff (rst_sys)
        swap |-> !fb_wr.we)
    else $error("framebuffer write during bank swap, addr %0d", fb_wr.addr);

endmodule

//--- design/pixel_out.sv
// pixel output stage
// palette lookup, blanking and sync alignment to the rgb path

`timescale 1ns/1ps

module pixel_out (
    input  logic                       clk_sys,
    input  logic                       rst_sys,
    input  logic [fb_pkg::cidxw-1:0]   cidx_rd,
    input  fb_pkg::sync_t              sync,
    output fb_pkg::sync_t              vga_sync,
    output fb_pkg::rgb_t               vga_rgb
);

    // sync delay line, last stage lines up with cidx_rd
    fb_pkg::sync_t sync_d [fb_pkg::lat_pix-1];

    always_ff @(posedge clk_sys) begin
        sync_d[0] <= sync;
        for (int i = 1; i < fb_pkg::lat_pix - 1; i++) begin
            sync_d[i] <= sync_d[i-1];
        end
        vga_sync <= sync_d[fb_pkg::lat_pix-2];  // lat_pix after timing
        if (sync_d[fb_pkg::lat_pix-2].de) begin
            vga_rgb <= fb_pkg::rgb_t'(fb_pkg::palette[cidx_rd]);
        end else begin
            vga_rgb <= '0;  // black in blanking
        end
        if (rst_sys) begin
            for (int i = 0; i < fb_pkg::lat_pix - 1; i++) begin
                sync_d[i] <= '0;
            end
            vga_sync <= '0;
            vga_rgb  <= '0;
        end
    end

endmodule

//--- design/demo_top.sv
// double-buffered square demo, top level
// timing, draw controller, framebuffer and vga output on clk_sys

`timescale 1ns/1ps

module demo_top (
    input  logic          clk_sys,
    input  logic          rst_sys,
    output fb_pkg::sync_t vga_sync,
    output fb_pkg::rgb_t  vga_rgb
);

    logic [fb_pkg::cordw-1:0] sx;     // screen position
    logic [fb_pkg::cordw-1:0] sy;
    fb_pkg::sync_t            sync;
    logic                     frame;  // start of vertical blanking

    fb_pkg::fb_wr_t           fb_wr;  // back-bank write
    logic                     swap;
    logic [fb_pkg::cidxw-1:0] cidx_rd;

    display_timing display_timing_inst (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .sx      (sx),
        .sy      (sy),
        .sync    (sync),
        .frame   (frame)
    );

    draw_ctrl draw_ctrl_inst (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .frame   (frame),
        .fb_wr   (fb_wr),
        .swap    (swap)
    );

    fb_double fb_double_inst (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .fb_wr   (fb_wr),
        .swap    (swap),
        .sx      (sx),
        .sy      (sy),
        .de      (sync.de),
        .cidx_rd (cidx_rd)
    );

    pixel_out pixel_out_inst (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .cidx_rd  (cidx_rd),
        .sync     (sync),
        .vga_sync (vga_sync),
        .vga_rgb  (vga_rgb)
    );

endmodule

//--- verif/demo_tb.sv
// testbench for the double-buffered square demo
// reference pixel model built from the vga outputs, checked by concurrent assertions

`timescale 1ns/1ps

module demo_tb;

    // draw k lands in the back bank and is shown after the following swap
    localparam int show_lag      = 2;
    localparam int num_frames    = 30;  // enough for position and colour to wrap
    localparam int frame_timeout = 2 * fb_pkg::h_total * fb_pkg::v_total;
    localparam int wrap_frame    = fb_pkg::sq_span + show_lag;  // square back at x 0

    logic          clk_sys;
    logic          rst_sys;
    fb_pkg::sync_t vga_sync;
    fb_pkg::rgb_t  vga_rgb;

    logic [fb_pkg::colrw-1:0] rgb_act;  // flat view of the rgb bundle

    int seed;
    int tail;  // trailing cycles after the last frame

    // model state, history up to the previous output cycle
    int   x_cnt;     // de cycles so far in this line
    int   y_cnt;     // active lines so far in this frame
    int   f_cnt;     // active frames so far
    int   hs_len;    // hsync high run
    int   vs_len;    // vsync high run
    int   since_hs;  // cycles since the last hsync rise
    int   hs_rises;
    logic de_q;
    logic vs_q;
    logic hs_q;

    // expected pixel
    int                       draw_k;
    int                       x0;
    logic                     in_sq;
    logic [fb_pkg::cidxw-1:0] sq_idx;
    logic [fb_pkg::colrw-1:0] exp_sq;
    logic [fb_pkg::colrw-1:0] exp_bg;
    logic [fb_pkg::colrw-1:0] exp_wrap;

    // checks reached
    int n_early;
    int n_square;
    int n_background;
    int n_wrap;

    demo_top demo_top_inst (
        .clk_sys  (clk_sys),
        .rst_sys  (rst_sys),
        .vga_sync (vga_sync),
        .vga_rgb  (vga_rgb)
    );

    assign rgb_act = vga_rgb;

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;  // 8 ns period
    end

    task automatic halt_failed();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic print_mismatch(input string check, input int expected, input int actual);
        $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", check, expected, actual);
        halt_failed();
    endtask

    task automatic explain_failure(input string what);
        $display("%s", what);
        halt_failed();
    endtask

    // one active frame further, bounded
    task automatic wait_next_frame();
        int start_f;
        int cycles;
        start_f = f_cnt;
        cycles  = 0;
        while (f_cnt == start_f && cycles <= frame_timeout) begin
            @(posedge clk_sys);
            cycles++;
        end
        if (f_cnt == start_f) begin
            explain_failure("timed out waiting for the next vsync pulse");
        end
    endtask

    // display rule: square of draw k at x k mod span, rows sq_y up, colour 1 + k mod 15
    always_comb begin
        draw_k = (f_cnt >= show_lag) ? f_cnt - show_lag : 0;
        x0     = draw_k % fb_pkg::sq_span;
        in_sq  = (f_cnt >= show_lag)
              && (x_cnt >= x0) && (x_cnt < x0 + fb_pkg::sq_size)
              && (y_cnt >= fb_pkg::sq_y) && (y_cnt < fb_pkg::sq_y + fb_pkg::sq_size);
        sq_idx = fb_pkg::cidxw'(1 + draw_k % fb_pkg::sq_colours);
        exp_sq = fb_pkg::palette[sq_idx];
        exp_bg = fb_pkg::palette[0];  // cleared pixels
        // draw sq_span, first one back at the left edge
        exp_wrap = fb_pkg::palette[1 + fb_pkg::sq_span % fb_pkg::sq_colours];
    end

    // counters follow the output syncs
    always @(posedge clk_sys) begin
        if (rst_sys) begin
            x_cnt        <= 0;
            y_cnt        <= 0;
            f_cnt        <= 0;
            hs_len       <= 0;
            vs_len       <= 0;
            since_hs     <= 0;
            hs_rises     <= 0;
            de_q         <= 1'b0;
            vs_q         <= 1'b0;
            hs_q         <= 1'b0;
            n_early      <= 0;
            n_square     <= 0;
            n_background <= 0;
            n_wrap       <= 0;
        end else begin
            de_q   <= vga_sync.de;
            vs_q   <= vga_sync.vsync;
            hs_q   <= vga_sync.hsync;
            x_cnt  <= vga_sync.de ? x_cnt + 1 : 0;
            hs_len <= vga_sync.hsync ? hs_len + 1 : 0;
            vs_len <= vga_sync.vsync ? vs_len + 1 : 0;
            if (de_q && !vga_sync.de) y_cnt <= y_cnt + 1;  // line done
            if (vga_sync.vsync && !vs_q) begin
                y_cnt <= 0;  // new frame
                f_cnt <= f_cnt + 1;
            end
            if (vga_sync.hsync && !hs_q) begin
                since_hs <= 1;
                hs_rises <= hs_rises + 1;
            end else begin
                since_hs <= since_hs + 1;
            end
            if (vga_sync.de && f_cnt < show_lag) n_early <= n_early + 1;
            if (vga_sync.de && in_sq) n_square <= n_square + 1;
            if (vga_sync.de && f_cnt >= show_lag && !in_sq) n_background <= n_background + 1;
            if (vga_sync.de && f_cnt == wrap_frame && x_cnt == 0 && y_cnt == fb_pkg::sq_y) begin
                n_wrap <= n_wrap + 1;
            end
        end
    end

    a_blank_black: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !vga_sync.de |-> rgb_act == '0)
    else print_mismatch("a_blank_black", 0, $sampled(rgb_act));

    a_de_per_line: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(vga_sync.de) |-> x_cnt == fb_pkg::h_active)
    else print_mismatch("a_de_per_line", fb_pkg::h_active, $sampled(x_cnt));

    a_hs_width: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(vga_sync.hsync) |-> hs_len == fb_pkg::h_sync)
    else print_mismatch("a_hs_width", fb_pkg::h_sync, $sampled(hs_len));

    // one hsync pulse per line
    a_hs_period: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(vga_sync.hsync) && hs_rises > 0 |-> since_hs == fb_pkg::h_total)
    else print_mismatch("a_hs_period", fb_pkg::h_total, $sampled(since_hs));

    a_lines_per_frame: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $rose(vga_sync.vsync) |-> y_cnt == fb_pkg::v_active)
    else print_mismatch("a_lines_per_frame", fb_pkg::v_active, $sampled(y_cnt));

    a_vs_width: assert property (@(posedge clk_sys) disable iff (rst_sys)
        $fell(vga_sync.vsync) |-> vs_len == fb_pkg::v_sync * fb_pkg::h_total)
    else print_mismatch("a_vs_width", fb_pkg::v_sync * fb_pkg::h_total, $sampled(vs_len));

    // nothing drawn has reached the front bank yet
    a_early_black: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vga_sync.de && f_cnt < show_lag |-> rgb_act == exp_bg)
    else print_mismatch("a_early_black", $sampled(exp_bg), $sampled(rgb_act));

    a_square: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vga_sync.de && in_sq |-> rgb_act == exp_sq)
    else print_mismatch("a_square", $sampled(exp_sq), $sampled(rgb_act));

    a_background: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vga_sync.de && f_cnt >= show_lag && !in_sq |-> rgb_act == exp_bg)
    else print_mismatch("a_background", $sampled(exp_bg), $sampled(rgb_act));

    a_wrap: assert property (@(posedge clk_sys) disable iff (rst_sys)
        vga_sync.de && f_cnt == wrap_frame && x_cnt == 0 && y_cnt == fb_pkg::sq_y
        |-> rgb_act == exp_wrap)
    else print_mismatch("a_wrap", $sampled(exp_wrap), $sampled(rgb_act));

    initial begin
        seed    = 71177;
        rst_sys = 1'b1;
        repeat (8) @(posedge clk_sys);
        #1 rst_sys = 1'b0;  // release just after the edge
        for (int i = 0; i < num_frames; i++) begin
            wait_next_frame();
        end
        tail = $random(seed) & 7;
        repeat (tail + 1) @(posedge clk_sys);
        if (n_early > 0 && n_square > 0 && n_background > 0 && n_wrap > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            explain_failure("some pixel checks were never reached during the run");
        end
    end

endmodule

//--- build.f
design/fb_pkg.sv
design/bram_sdp.sv
design/display_timing.sv
design/draw_ctrl.sv
design/fb_double.sv
design/pixel_out.sv
design/demo_top.sv
verif/demo_tb.sv

//--- Makefile
# Verilator build for the double-buffered square demo

VERILATOR ?= verilator
TOP       ?= demo_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench gives a failing exit status
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
